//--- src.f
hw/ooo_pkg.sv
hw/instruction_queue.sv
hw/decode.sv
hw/register_file.sv
hw/reservation_station.sv
hw/alu.sv
hw/result_bus.sv
hw/ooo_core.sv
dv/ooo_core_chk.sv
dv/ooo_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= ooo_core_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/ooo_core_tb.sv
module ooo_core_tb import ooo_pkg::*; ();

  logic      clk_100mhz;
  logic      rst;
  logic      inst_valid;
  word_t     inst;
  logic      inst_ready;
  logic      out_valid;
  reg_addr_t out_rd;
  tag_t      out_tag;
  word_t     out_value;
  logic      out_ready;

  // reference state, expected results kept in issue order
  word_t     model_regs [32];
  word_t     exp_val [$];
  reg_addr_t exp_rd [$];
  tag_t      exp_tag [$];
  word_t     last_out [32];  // last value seen on the output per rd
  int        match;
  int        issue_cnt;
  int        results;
  int        errors;
  int        tests;
  int        out_mode;  // 0 low, 1 high, 2 random

  ooo_core #(.QUEUE_DEPTH(4)) dut (
    .clk_100mhz(clk_100mhz),
    .rst(rst),
    .inst_valid(inst_valid),
    .inst(inst),
    .inst_ready(inst_ready),
    .out_valid(out_valid),
    .out_rd(out_rd),
    .out_tag(out_tag),
    .out_value(out_value),
    .out_ready(out_ready)
  );

  always #5 clk_100mhz = ~clk_100mhz;

  always @(posedge clk_100mhz) begin
    #1;
    if (out_mode == 0) out_ready = 1'b0;
    else if (out_mode == 1) out_ready = 1'b1;
    else out_ready = 1'($urandom_range(1, 0));
  end

  // oldest outstanding entry that carries this tag
  function automatic int oldest_with_tag(input tag_t t);
    for (int i = 0; i < exp_tag.size(); i++) begin
      if (exp_tag[i] == t) return i;
    end
    return -1;
  endfunction

  // result monitor
  always @(posedge clk_100mhz) begin
    if (!rst && out_valid && out_ready) begin
      results++;
      last_out[out_rd] = out_value;
      match = oldest_with_tag(out_tag);
      assert (match >= 0) else begin
        errors++;
        $display("unexpected result with tag %0d at %0t", out_tag, $time);
      end
      if (match >= 0) begin
        assert (out_rd == exp_rd[match]) else begin
          errors++;
          $display("Fail at %0t: out_rd expected %0d got %0d", $time, exp_rd[match], out_rd);
        end
        assert (out_value == exp_val[match]) else begin
          errors++;
          $display("Fail at %0t: out_value expected %h got %h", $time,
                   exp_val[match], out_value);
        end
        exp_val.delete(match);
        exp_rd.delete(match);
        exp_tag.delete(match);
      end
    end
  end

  function automatic word_t ref_alu(input logic [2:0] f3, input logic alt,
                                    input word_t a, input word_t b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'b0, $signed(a) < $signed(b)};
      3'd3:    return {31'b0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                  input reg_addr_t rs1, input logic [2:0] f3,
                                  input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                  input logic [2:0] f3, input reg_addr_t rd);
    return {imm, rs1, f3, rd, OPC_OPIMM};
  endfunction

  // random alu instruction, registers in lo..hi
  function automatic word_t rand_alu(input int lo, input int hi);
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [6:0]  f7;
    reg_addr_t   rd;
    reg_addr_t   ra;
    reg_addr_t   rb;
    int          kind;
    f3   = 3'($urandom_range(7, 0));
    imm  = 12'($urandom);
    rd   = reg_addr_t'($urandom_range(hi, lo));
    ra   = reg_addr_t'($urandom_range(hi, lo));
    rb   = reg_addr_t'($urandom_range(hi, lo));
    kind = $urandom_range(2, 0);
    f7   = (f3 == 3'd0 || f3 == 3'd5) && ($urandom_range(1, 0) == 1) ? 7'h20 : 7'h00;
    if (kind == 0) return enc_r(f7, rb, ra, f3, rd);
    if (kind == 2) return {20'($urandom), rd, OPC_LUI};
    if (f3 == 3'd1) imm = {7'h00, imm[4:0]};
    if (f3 == 3'd5) imm = {f7, imm[4:0]};
    return enc_i(imm, ra, f3, rd);
  endfunction

  function automatic word_t rand_illegal();
    logic [6:0] opc;
    case ($urandom_range(3, 0))
      0:       opc = 7'h63;  // branch
      1:       opc = 7'h03;  // load
      2:       opc = 7'h23;  // store
      default: opc = 7'h6f;  // jal
    endcase
    return {25'($urandom), opc};
  endfunction

  function automatic word_t rand_mixed(input int lo, input int hi);
    if ($urandom_range(7, 0) == 0) return rand_illegal();
    return rand_alu(lo, hi);
  endfunction

  // in-order execution of an accepted word
  task automatic accept_inst(input word_t w);
    logic [6:0] opc;
    logic [2:0] f3;
    word_t      a;
    word_t      v;
    tag_t       t;
    opc = w[6:0];
    f3  = w[14:12];
    a   = model_regs[w[19:15]];
    if (opc == OPC_OP) v = ref_alu(f3, w[30], a, model_regs[w[24:20]]);
    else if (opc == OPC_OPIMM) v = ref_alu(f3, (f3 == 3'd5) && w[30], a,
                                           {{20{w[31]}}, w[31:20]});
    else if (opc == OPC_LUI) v = {w[31:12], 12'b0};
    else return;  // dropped, takes no tag
    t = tag_t'(issue_cnt);
    exp_val.push_back(v);
    exp_rd.push_back(w[11:7]);
    exp_tag.push_back(t);
    issue_cnt++;
    if (w[11:7] != 5'd0) model_regs[w[11:7]] = v;
  endtask

  task automatic expect_word(input string name, input word_t got, input word_t exp);
    assert (got == exp) else begin
      errors++;
      $display("Fail at %0t: %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic abort_run(input string what);
    $display("timeout: %s at %0t", what, $time);
    $display("TEST FAILED");
    $finish;
  endtask

  // called 1 unit after an edge
  task automatic send(input word_t w, input int max_idle);
    int n;
    logic done;
    n    = 0;
    done = 1'b0;
    repeat ($urandom_range(max_idle, 0)) @(posedge clk_100mhz) #1;
    inst_valid = 1'b1;
    inst       = w;
    while (!done && n < 200) begin
      @(posedge clk_100mhz);
      done = inst_ready;
      n++;
    end
    if (!done) begin
      abort_run("inst_ready stuck low");
    end else begin
      accept_inst(w);
      #1 inst_valid = 1'b0;
    end
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (exp_tag.size() != 0 && n < 500) begin
      @(posedge clk_100mhz) #1;
      n++;
    end
    if (exp_tag.size() != 0) abort_run("results missing at drain");
  endtask

  task automatic finish_test(input string name, input int err_before);
    drain();
    tests++;
    $display("test %0d %s: %s", tests, name, (errors == err_before) ? "pass" : "fail");
  endtask

  initial begin
    int e;
    int n;
    logic stalled;
    word_t w;
    void'($urandom(32'h123e_2556));
    clk_100mhz = 1'b0;
    rst        = 1'b1;
    inst_valid = 1'b0;
    inst       = '0;
    out_ready  = 1'b0;
    out_mode   = 1;
    issue_cnt  = 0;
    results    = 0;
    errors     = 0;
    tests      = 0;
    match      = 0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
      last_out[i]   = '0;
    end
    repeat (4) @(posedge clk_100mhz);
    #1 rst = 1'b0;

    e = errors;  // sources from x0 only
    for (int i = 0; i < 24; i++) begin
      w = rand_alu(0, 0) | {20'b0, 5'($urandom_range(7, 1)), 7'b0};
      send(w, 0);
    end
    finish_test("independent full rate", e);

    e = errors;
    for (int i = 0; i < 40; i++) send(rand_alu(1, 3), 1);
    finish_test("raw chains", e);

    e = errors;
    out_mode = 0;
    stalled  = 1'b0;
    n        = 0;
    w        = rand_alu(1, 7);
    inst_valid = 1'b1;
    inst       = w;
    while (!stalled && n < 40) begin
      @(posedge clk_100mhz);
      if (inst_ready) begin
        accept_inst(w);
        w = rand_alu(1, 7);
      end else begin
        stalled = 1'b1;
      end
      #1 inst = w;
      n++;
    end
    inst_valid = 1'b0;
    assert (stalled) else begin
      errors++;
      $display("inst_ready never dropped under back-pressure");
    end
    out_mode = 2;
    for (int i = 0; i < 60; i++) send(rand_mixed(0, 7), 2);
    finish_test("back-pressure", e);

    e = errors;
    out_mode = 1;
    n = results;
    for (int i = 0; i < 12; i++) send(rand_illegal(), 0);
    repeat (20) @(posedge clk_100mhz) #1;
    assert (results == n) else begin
      errors++;
      $display("nop produced a result");
    end
    send(enc_i(12'd9, 5'd0, 3'd0, 5'd1), 0);  // tag must follow on
    finish_test("nops dropped", e);

    e = errors;
    send(enc_i(12'd5, 5'd0, 3'd0, 5'd0), 0);           // addi x0, x0, 5
    send(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd1), 0);     // add x1, x0, x0
    send(enc_i(12'hff9, 5'd0, 3'd0, 5'd2), 0);         // addi x2, x0, -7
    send(enc_r(7'h20, 5'd2, 5'd0, 3'd0, 5'd3), 0);     // sub x3, x0, x2
    send(enc_i(12'd2, 5'd0, 3'd0, 5'd5), 0);
    send(enc_r(7'h20, 5'd5, 5'd2, 3'd5, 5'd4), 0);     // sra x4, x2, x5
    send(enc_i(12'h401, 5'd2, 3'd5, 5'd6), 0);         // srai x6, x2, 1
    send(enc_r(7'h00, 5'd2, 5'd0, 3'd3, 5'd7), 0);     // sltu x7, x0, x2
    drain();
    expect_word("out_value x0", last_out[0], 32'd5);
    expect_word("out_value x1", last_out[1], 32'd0);
    expect_word("out_value x2", last_out[2], 32'hffff_fff9);
    expect_word("out_value x3", last_out[3], 32'd7);
    expect_word("out_value x4", last_out[4], 32'hffff_fffe);
    expect_word("out_value x6", last_out[6], 32'hffff_fffc);
    expect_word("out_value x7", last_out[7], 32'd1);
    finish_test("x0 and signed ops", e);

    e = errors;
    out_mode = 2;
    for (int i = 0; i < 30; i++) send(rand_mixed(0, 7), 1);
    for (int r = 1; r < 8; r++) send(enc_r(7'h00, 5'd0, 5'(r), 3'd0, 5'(r)), 0);
    finish_test("register read-out", e);

    $display("tests %0d, results %0d, errors %0d", tests, results, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- dv/ooo_core_chk.sv
module ooo_core_chk import ooo_pkg::*; (
  input wire       clk_100mhz,
  input wire       rst,
  input wire       inst_ready,
  input wire       out_valid,
  input wire       out_ready,
  input reg_addr_t out_rd,
  input tag_t      out_tag,
  input word_t     out_value,
  input wire       issue,
  input tag_t      new_tag,
  input wire       bcast_valid,
  input tag_t      bcast_tag
);

  logic [7:0] live;  // tags issued but not yet broadcast

  always_ff @(posedge clk_100mhz) begin
    if (rst) begin
      live <= '0;
    end else begin
      if (bcast_valid) live[bcast_tag] <= 1'b0;
      if (issue) live[new_tag] <= 1'b1;
    end
  end

  a_out_hold: assert property (@(posedge clk_100mhz) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_rd) && $stable(out_tag)
      && $stable(out_value))
    else $error("out stream changed while stalled");

  a_tag_once: assert property (@(posedge clk_100mhz) disable iff (rst)
    bcast_valid |-> live[bcast_tag])
    else $error("tag broadcast without a matching issue");

  a_ready_after_rst: assert property (@(posedge clk_100mhz) $fell(rst) |-> inst_ready)
    else $error("inst_ready low after reset");

endmodule

bind ooo_core ooo_core_chk u_chk (
  .clk_100mhz(clk_100mhz),
  .rst(rst),
  .inst_ready(inst_ready),
  .out_valid(out_valid),
  .out_ready(out_ready),
  .out_rd(out_rd),
  .out_tag(out_tag),
  .out_value(out_value),
  .issue(issue),
  .new_tag(new_tag),
  .bcast_valid(bcast_valid),
  .bcast_tag(bcast_tag)
);

//--- hw/ooo_core.sv
module ooo_core import ooo_pkg::*; #(
  parameter int QUEUE_DEPTH = 4  // power of two
) (
  input  wire       clk_100mhz,
  input  wire       rst,
  input  wire       inst_valid,
  input  word_t     inst,
  output logic      inst_ready,
  output logic      out_valid,
  output reg_addr_t out_rd,
  output tag_t      out_tag,
  output word_t     out_value,
  input  wire       out_ready
);

  logic      head_valid;
  logic      head_ready;
  word_t     head;
  itype_e    itype;
  alu_func_t func;
  word_t     imm;
  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;
  logic      issue;
  logic      rs_free;
  logic      use_imm;
  word_t     val1;
  word_t     val2;
  word_t     op_b;
  logic      busy1;
  logic      busy2;
  logic      rdy_b;
  tag_t      tag1;
  tag_t      tag2;
  tag_t      new_tag;

  logic      disp_valid;
  word_t     disp_a;
  word_t     disp_b;
  alu_func_t disp_func;
  tag_t      disp_tag;
  reg_addr_t disp_rd;
  logic      alu_ready;
  logic      res_valid;
  word_t     res_value;
  tag_t      res_tag;
  reg_addr_t res_rd;
  logic      bus_ready;

  logic      bcast_valid;
  tag_t      bcast_tag;
  reg_addr_t bcast_rd;
  word_t     bcast_value;

  // nops leave the queue without a station slot
  assign head_ready = rs_free || (itype == NOP);
  assign issue      = head_valid && rs_free && (itype != NOP);

  assign use_imm = (itype == OPIMM) || (itype == LUI);
  assign op_b    = use_imm ? imm : val2;
  assign rdy_b   = use_imm || !busy2;  // immediate is ready at once

  instruction_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_iq (
    .clk_100mhz(clk_100mhz),
    .rst(rst),
    .inst_valid(inst_valid),
    .inst(inst),
    .inst_ready(inst_ready),
    .head_valid(head_valid),
    .head(head),
    .head_ready(head_ready)
  );

  decode u_dec (
    .instr(head),
    .itype(itype),
    .func(func),
    .imm(imm),
    .rs1(rs1),
    .rs2(rs2),
    .rd(rd)
  );

  register_file u_rf (
    .clk_100mhz(clk_100mhz),
    .rst(rst),
    .issue(issue),
    .rs1(rs1),
    .rs2(rs2),
    .rd(rd),
    .val1(val1),
    .val2(val2),
    .busy1(busy1),
    .busy2(busy2),
    .tag1(tag1),
    .tag2(tag2),
    .new_tag(new_tag),
    .bcast_valid(bcast_valid),
    .bcast_tag(bcast_tag),
    .bcast_rd(bcast_rd),
    .bcast_value(bcast_value)
  );

  reservation_station u_rs (
    .clk_100mhz(clk_100mhz),
    .rst(rst),
    .issue(issue),
    .func(func),
    .tag(new_tag),
    .rd_in(rd),
    .val_a(val1),
    .rdy_a(!busy1),
    .tag_a(tag1),
    .val_b(op_b),
    .rdy_b(rdy_b),
    .tag_b(tag2),
    .free(rs_free),
    .disp_valid(disp_valid),
    .disp_a(disp_a),
    .disp_b(disp_b),
    .disp_func(disp_func),
    .disp_tag(disp_tag),
    .disp_rd(disp_rd),
    .alu_ready(alu_ready),
    .bcast_valid(bcast_valid),
    .bcast_tag(bcast_tag),
    .bcast_value(bcast_value)
  );

  alu u_alu (
    .clk_100mhz(clk_100mhz),
    .rst(rst),
    .disp_valid(disp_valid),
    .disp_a(disp_a),
    .disp_b(disp_b),
    .disp_func(disp_func),
    .disp_tag(disp_tag),
    .disp_rd(disp_rd),
    .alu_ready(alu_ready),
    .res_valid(res_valid),
    .res_value(res_value),
    .res_tag(res_tag),
    .res_rd(res_rd),
    .bus_ready(bus_ready)
  );

  result_bus u_bus (
    .clk_100mhz(clk_100mhz),
    .rst(rst),
    .res_valid(res_valid),
    .res_value(res_value),
    .res_tag(res_tag),
    .res_rd(res_rd),
    .bus_ready(bus_ready),
    .out_valid(out_valid),
    .out_rd(out_rd),
    .out_tag(out_tag),
    .out_value(out_value),
    .out_ready(out_ready),
    .bcast_valid(bcast_valid),
    .bcast_tag(bcast_tag),
    .bcast_rd(bcast_rd),
    .bcast_value(bcast_value)
  );

endmodule

//--- hw/result_bus.sv
module result_bus import ooo_pkg::*; (
  input  wire       clk_100mhz,
  input  wire       rst,
  input  wire       res_valid,
  input  word_t     res_value,
  input  tag_t      res_tag,
  input  reg_addr_t res_rd,
  output logic      bus_ready,
  output logic      out_valid,
  output reg_addr_t out_rd,
  output tag_t      out_tag,
  output word_t     out_value,
  input  wire       out_ready,
  output logic      bcast_valid,
  output tag_t      bcast_tag,
  output reg_addr_t bcast_rd,
  output word_t     bcast_value
);

  word_t      val_q [2];
  tag_t       tag_q [2];
  reg_addr_t  rd_q [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;
  logic       push;
  logic       pop;

  assign bus_ready = (count != 2'd2);
  assign out_valid = (count != 2'd0);
  assign out_value = val_q[rd_ptr];
  assign out_tag   = tag_q[rd_ptr];
  assign out_rd    = rd_q[rd_ptr];

  assign push = res_valid && bus_ready;
  assign pop  = out_valid && out_ready;

  // cdb fires with the external transfer
  assign bcast_valid = pop;
  assign bcast_tag   = out_tag;
  assign bcast_rd    = out_rd;
  assign bcast_value = out_value;

  always_ff @(posedge clk_100mhz) begin
    if (rst) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= ~wr_ptr;
      if (pop) rd_ptr <= ~rd_ptr;
      count <= count + {1'b0, push} - {1'b0, pop};
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (push) begin
      val_q[wr_ptr] <= res_value;
      tag_q[wr_ptr] <= res_tag;
      rd_q[wr_ptr]  <= res_rd;
    end
  end

endmodule

//--- hw/alu.sv
module alu import ooo_pkg::*; (
  input  wire       clk_100mhz,
  input  wire       rst,
  input  wire       disp_valid,
  input  word_t     disp_a,
  input  word_t     disp_b,
  input  alu_func_t disp_func,
  input  tag_t      disp_tag,
  input  reg_addr_t disp_rd,
  output logic      alu_ready,
  output logic      res_valid,
  output word_t     res_value,
  output tag_t      res_tag,
  output reg_addr_t res_rd,
  input  wire       bus_ready
);

  word_t result;
  logic  take;

  always_comb begin
    case (disp_func)
      ALU_ADD:   result = disp_a + disp_b;
      ALU_SUB:   result = disp_a - disp_b;
      ALU_SLL:   result = disp_a << disp_b[4:0];
      ALU_SLT:   result = {31'b0, $signed(disp_a) < $signed(disp_b)};
      ALU_SLTU:  result = {31'b0, disp_a < disp_b};
      ALU_XOR:   result = disp_a ^ disp_b;
      ALU_SRL:   result = disp_a >> disp_b[4:0];
      ALU_SRA:   result = $signed(disp_a) >>> disp_b[4:0];
      ALU_OR:    result = disp_a | disp_b;
      ALU_AND:   result = disp_a & disp_b;
      default:   result = disp_b;  // pass-b for lui
    endcase
  end

  assign alu_ready = !res_valid || bus_ready;  // empty or draining
  assign take      = disp_valid && alu_ready;

  always_ff @(posedge clk_100mhz) begin
    if (rst) res_valid <= 1'b0;
    else if (take) res_valid <= 1'b1;
    else if (bus_ready) res_valid <= 1'b0;
  end

  always_ff @(posedge clk_100mhz) begin
    if (take) begin
      res_value <= result;
      res_tag   <= disp_tag;
      res_rd    <= disp_rd;
    end
  end

endmodule

//--- hw/reservation_station.sv
module reservation_station import ooo_pkg::*; (
  input  wire       clk_100mhz,
  input  wire       rst,
  input  wire       issue,
  input  alu_func_t func,
  input  tag_t      tag,
  input  reg_addr_t rd_in,
  input  word_t     val_a,
  input  wire       rdy_a,
  input  tag_t      tag_a,
  input  word_t     val_b,
  input  wire       rdy_b,
  input  tag_t      tag_b,
  output logic      free,
  output logic      disp_valid,
  output word_t     disp_a,
  output word_t     disp_b,
  output alu_func_t disp_func,
  output tag_t      disp_tag,
  output reg_addr_t disp_rd,
  input  wire       alu_ready,
  input  wire       bcast_valid,
  input  tag_t      bcast_tag,
  input  word_t     bcast_value
);

  logic [1:0] valid;
  logic [1:0] age;     // set on the older of two live entries
  logic [1:0] ra;
  logic [1:0] rb;
  logic [1:0] ready;
  alu_func_t  e_func [2];
  tag_t       e_tag [2];
  reg_addr_t  e_rd [2];
  tag_t       qa [2];
  tag_t       qb [2];
  word_t      va [2];
  word_t      vb [2];
  logic       ins_slot;
  logic       sel;
  logic       fire;

  assign free     = !(valid[0] && valid[1]);
  assign ins_slot = valid[0];  // lowest empty slot
  assign ready    = valid & ra & rb;

  // both ready -> older one goes
  assign sel        = (ready == 2'b11) ? age[1] : ready[1];
  assign disp_valid = |ready;
  assign fire       = disp_valid && alu_ready;

  assign disp_a    = va[sel];
  assign disp_b    = vb[sel];
  assign disp_func = e_func[sel];
  assign disp_tag  = e_tag[sel];
  assign disp_rd   = e_rd[sel];

  always_ff @(posedge clk_100mhz) begin
    if (rst) begin
      valid <= '0;
      age   <= '0;
    end else begin
      if (fire) valid[sel] <= 1'b0;
      if (issue) begin
        valid[ins_slot] <= 1'b1;
        age[ins_slot]   <= 1'b0;
        age[~ins_slot]  <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_100mhz) begin
    for (int i = 0; i < 2; i++) begin
      if (issue && (ins_slot == i[0])) begin
        e_func[i] <= func;
        e_tag[i]  <= tag;
        e_rd[i]   <= rd_in;
        va[i]     <= val_a;
        ra[i]     <= rdy_a;
        qa[i]     <= tag_a;
        vb[i]     <= val_b;
        rb[i]     <= rdy_b;
        qb[i]     <= tag_b;
      end else begin
        // snoop the bus for waiting operands
        if (!ra[i] && bcast_valid && (qa[i] == bcast_tag)) begin
          va[i] <= bcast_value;
          ra[i] <= 1'b1;
        end
        if (!rb[i] && bcast_valid && (qb[i] == bcast_tag)) begin
          vb[i] <= bcast_value;
          rb[i] <= 1'b1;
        end
      end
    end
  end

endmodule

//--- hw/register_file.sv
module register_file import ooo_pkg::*; (
  input  wire       clk_100mhz,
  input  wire       rst,
  input  wire       issue,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  input  reg_addr_t rd,
  output word_t     val1,
  output word_t     val2,
  output logic      busy1,
  output logic      busy2,
  output tag_t      tag1,
  output tag_t      tag2,
  output tag_t      new_tag,
  input  wire       bcast_valid,
  input  tag_t      bcast_tag,
  input  reg_addr_t bcast_rd,
  input  word_t     bcast_value
);

  word_t       regs [32];
  tag_t        tags [32];   // only meaningful while busy
  logic [31:0] busy;        // bit 0 is never set
  tag_t        tag_cnt;
  logic        bcast_hit;

  assign new_tag = tag_cnt;

  // older producers of a renamed register are dropped here
  assign bcast_hit = bcast_valid && busy[bcast_rd] && (tags[bcast_rd] == bcast_tag);

  always_comb begin
    val1  = regs[rs1];
    busy1 = busy[rs1];
    tag1  = tags[rs1];
    val2  = regs[rs2];
    busy2 = busy[rs2];
    tag2  = tags[rs2];
    if (busy1 && bcast_valid && (bcast_tag == tag1)) begin
      val1  = bcast_value;  // same-cycle wakeup
      busy1 = 1'b0;
    end
    if (busy2 && bcast_valid && (bcast_tag == tag2)) begin
      val2  = bcast_value;
      busy2 = 1'b0;
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (rst) begin
      busy    <= '0;
      tag_cnt <= '0;
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (bcast_hit) begin
        regs[bcast_rd] <= bcast_value;
        busy[bcast_rd] <= 1'b0;
      end
      if (issue) begin
        tag_cnt <= tag_cnt + 1'b1;  // x0 writes still take a tag
        if (rd != '0) busy[rd] <= 1'b1;  // issue wins over writeback
      end
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (issue && rd != '0) begin
      tags[rd] <= tag_cnt;
    end
  end

endmodule

//--- hw/decode.sv
module decode import ooo_pkg::*; (
  input  word_t     instr,
  output itype_e    itype,
  output alu_func_t func,
  output word_t     imm,
  output reg_addr_t rs1,
  output reg_addr_t rs2,
  output reg_addr_t rd
);

  logic [6:0] opcode;
  logic [2:0] funct3;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];

  // funct3 to alu code, alt picks sub/sra
  function automatic alu_func_t alu_sel(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // unused source fields stay at x0, which is never busy
  always_comb begin
    itype = NOP;
    func  = ALU_ADD;
    imm   = '0;
    rs1   = '0;
    rs2   = '0;
    rd    = '0;
    case (opcode)
      OPC_OP: begin
        itype = OP;
        func  = alu_sel(funct3, instr[30]);
        rs1   = instr[19:15];
        rs2   = instr[24:20];
        rd    = instr[11:7];
      end
      OPC_OPIMM: begin
        itype = OPIMM;
        // no subi, bit 30 only matters for srai
        func  = alu_sel(funct3, (funct3 == 3'b101) && instr[30]);
        imm   = {{20{instr[31]}}, instr[31:20]};  // i-type, sign extended
        rs1   = instr[19:15];
        rd    = instr[11:7];
      end
      OPC_LUI: begin
        itype = LUI;
        func  = ALU_PASSB;
        imm   = {instr[31:12], 12'b0};  // u-type
        rd    = instr[11:7];
      end
      default: ;  // branches, loads, unknown -> nop
    endcase
  end

endmodule

//--- hw/instruction_queue.sv
module instruction_queue import ooo_pkg::*; #(
  parameter int QUEUE_DEPTH = 4
) (
  input  wire   clk_100mhz,
  input  wire   rst,
  input  wire   inst_valid,
  input  word_t inst,
  output logic  inst_ready,
  output logic  head_valid,
  output word_t head,
  input  wire   head_ready
);

  localparam int IDX_W = $clog2(QUEUE_DEPTH);

  // pointers carry one extra wrap bit
  logic [IDX_W:0] wr_ptr;
  logic [IDX_W:0] rd_ptr;
  word_t          mem [QUEUE_DEPTH];
  logic           full;
  logic           push;
  logic           pop;

  assign full       = (wr_ptr == {~rd_ptr[IDX_W], rd_ptr[IDX_W-1:0]});
  assign inst_ready = !full;
  assign head_valid = (wr_ptr != rd_ptr);
  assign head       = mem[rd_ptr[IDX_W-1:0]];

  assign push = inst_valid && inst_ready;
  assign pop  = head_valid && head_ready;

  always_ff @(posedge clk_100mhz) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;  // push and pop may overlap
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (push) begin
      mem[wr_ptr[IDX_W-1:0]] <= inst;
    end
  end

endmodule

//--- hw/ooo_pkg.sv
package ooo_pkg;

  typedef logic [31:0] word_t;      // data or instruction word
  typedef logic [4:0]  reg_addr_t;  // architectural register index
  typedef logic [2:0]  tag_t;       // producer tag, wraps mod 8
  typedef logic [3:0]  alu_func_t;

  // alu function codes
  localparam alu_func_t ALU_ADD   = 4'd0;
  localparam alu_func_t ALU_SUB   = 4'd1;
  localparam alu_func_t ALU_SLL   = 4'd2;
  localparam alu_func_t ALU_SLT   = 4'd3;
  localparam alu_func_t ALU_SLTU  = 4'd4;
  localparam alu_func_t ALU_XOR   = 4'd5;
  localparam alu_func_t ALU_SRL   = 4'd6;
  localparam alu_func_t ALU_SRA   = 4'd7;
  localparam alu_func_t ALU_OR    = 4'd8;
  localparam alu_func_t ALU_AND   = 4'd9;
  localparam alu_func_t ALU_PASSB = 4'd10;  // lui, result is operand b

  // only the integer alu subset is issued, the rest decodes as nop
  typedef enum logic [1:0] {
    OP,
    OPIMM,
    LUI,
    NOP
  } itype_e;

  // major opcodes
  localparam logic [6:0] OPC_OP    = 7'b0110011;
  localparam logic [6:0] OPC_OPIMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI   = 7'b0110111;

endpackage
